/* dv/tb_z80_vdp_bus.sv */
//******************************
// Z80 VDP write path testbench
// Drives CPU port writes from a vector file and checks
// the decoded VRAM and register events in order
//******************************

`timescale 1ns/10ps

`include "vdp_params.svh"

module tb_z80_vdp_bus;

    import vdp_pkg::*;

    localparam int PHI_PERIOD = 40;         // ns
    localparam int PX_PERIOD  = 30;         // ns and unrelated to phi
    localparam int RST_CYCLES = 10;         // phi cycles
    localparam int DRIVE_DLY  = 2;          // ns after the rising phi edge
    localparam int MAX_VEC    = 128;
    localparam int COLS       = 5;          // mode, data, kind, idx, value
    localparam int KIND_NONE  = 0;
    localparam int KIND_VRAM  = 1;
    localparam int KIND_REG   = 2;

    logic                   phi;
    logic                   pxclk;
    logic                   rst_n;
    logic                   cpu_wr_tick;
    logic                   cpu_mode;
    logic [`VDP_DATA_W-1:0] cpu_din;
    vram_wr_t               vram_wr;
    reg_wr_t                reg_wr;

    logic [15:0]    vec_mem [0:MAX_VEC*COLS-1];     // Flat with COLS words per vector
    int             num_vec;
    int             events_expected;
    int             events_seen;
    int             errors;
    int             waiting_vec;                    // Vector the checker waits on
    bit             load_done;

    // Events seen at the DUT outputs with the oldest first
    int             ev_kind_q [$];
    int             ev_idx_q [$];
    int             ev_val_q [$];

    always #(PHI_PERIOD / 2) phi = ~phi;
    always #(PX_PERIOD / 2) pxclk = ~pxclk;

    z80_vdp_bus dut0 (
        .phi         (phi),
        .pxclk       (pxclk),
        .rst_n       (rst_n),
        .cpu_wr_tick (cpu_wr_tick),
        .cpu_mode    (cpu_mode),
        .cpu_din     (cpu_din),
        .vram_wr     (vram_wr),
        .reg_wr      (reg_wr)
    );

    //******************************
    // Output monitor
    //******************************

    // Sampled on the falling pxclk edge halfway between DUT updates
    always @(negedge pxclk) begin
        if (!rst_n) begin
            if (vram_wr.we || reg_wr.we) begin
                errors++;
                $display("Output strobe seen while reset is asserted at %0t", $time);
            end
        end else begin
            if (vram_wr.we) begin
                ev_kind_q.push_back(KIND_VRAM);
                ev_idx_q.push_back(int'(vram_wr.addr));
                ev_val_q.push_back(int'(vram_wr.data));
                events_seen++;
            end
            if (reg_wr.we) begin
                ev_kind_q.push_back(KIND_REG);
                ev_idx_q.push_back(int'(reg_wr.num));
                ev_val_q.push_back(int'(reg_wr.val));
                events_seen++;
            end
        end
    end

    function automatic int vec_field(input int vi, input int col);
        return int'(vec_mem[vi*COLS+col]);
    endfunction

    task automatic load_vectors();
        int i;
        for (i = 0; i < MAX_VEC*COLS; i++) begin
            vec_mem[i] = 16'hF000 | 16'(i);     // Mode column above 1 marks no vector
        end
        $readmemh("dv/vdp_vectors.txt", vec_mem);
        num_vec         = 0;
        events_expected = 0;
        while (num_vec < MAX_VEC && vec_mem[num_vec*COLS] <= 16'd1) begin
            if (vec_field(num_vec, 2) != KIND_NONE) begin
                events_expected++;
            end
            num_vec++;
        end
        if (num_vec == 0) begin
            errors++;
            $display("No vectors were read from dv/vdp_vectors.txt");
        end
        load_done = 1'b1;
    endtask

    // One write per vector spaced by the CPU side minimum gap
    task automatic run_driver();
        int vi;
        for (vi = 0; vi < num_vec; vi++) begin
            repeat (`VDP_MIN_WR_GAP) @(posedge phi);
            #(DRIVE_DLY);
            cpu_wr_tick = 1'b1;
            cpu_mode    = vec_mem[vi*COLS][0];
            cpu_din     = vec_mem[vi*COLS+1][`VDP_DATA_W-1:0];
            @(posedge phi);
            #(DRIVE_DLY);
            cpu_wr_tick = 1'b0;
        end
    endtask

    task automatic compare_event(input int vi);
        int     exp_kind;
        int     exp_idx;
        int     exp_val;
        int     got_kind;
        int     got_idx;
        int     got_val;
        string  idx_name;
        string  val_name;
        exp_kind = vec_field(vi, 2);
        exp_idx  = vec_field(vi, 3);
        exp_val  = vec_field(vi, 4);
        got_kind = ev_kind_q.pop_front();
        got_idx  = ev_idx_q.pop_front();
        got_val  = ev_val_q.pop_front();
        idx_name = (exp_kind == KIND_REG) ? "num" : "addr";
        val_name = (exp_kind == KIND_REG) ? "val" : "data";
        if (got_kind != exp_kind) begin
            errors++;
            $display("** Error %0t: vector %0d kind got %0d expected %0d",
                     $time, vi, got_kind, exp_kind);
        end
        if (got_idx != exp_idx) begin
            errors++;
            $display("** Error %0t: vector %0d %s got %h expected %h",
                     $time, vi, idx_name, got_idx[13:0], exp_idx[13:0]);
        end
        if (got_val != exp_val) begin
            errors++;
            $display("** Error %0t: vector %0d %s got %h expected %h",
                     $time, vi, val_name, got_val[7:0], exp_val[7:0]);
        end
    endtask

    // Matches events to vectors in CPU write order
    task automatic run_checker();
        int vi;
        for (vi = 0; vi < num_vec; vi++) begin
            if (vec_field(vi, 2) != KIND_NONE) begin
                waiting_vec = vi;
                while (ev_kind_q.size() == 0) begin
                    @(posedge pxclk);
                end
                compare_event(vi);
            end
        end
        waiting_vec = -1;
    endtask

    //******************************
    // Main sequence
    //******************************

    initial begin
        phi         = 1'b0;
        pxclk       = 1'b0;
        rst_n       = 1'b0;
        cpu_wr_tick = 1'b0;
        cpu_mode    = 1'b0;
        cpu_din     = '0;
        errors      = 0;
        events_seen = 0;
        waiting_vec = -1;
        load_vectors();
        repeat (RST_CYCLES) @(posedge phi);
        #(DRIVE_DLY);
        rst_n = 1'b1;
        fork
            run_driver();
            run_checker();
        join
        repeat (2 * (`VDP_MIN_WR_GAP + 4)) @(posedge phi);     // Room for late strays
        if (ev_kind_q.size() != 0) begin
            errors += ev_kind_q.size();
            $display("%0d extra output events appeared with no vector expecting them",
                     ev_kind_q.size());
        end
        $display("Errors: %0d, events seen: %0d, events expected: %0d",
                 errors, events_seen, events_expected);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        longint limit_ns;
        wait (load_done);
        limit_ns = (longint'(num_vec) * (`VDP_MIN_WR_GAP + 4) + RST_CYCLES) * PHI_PERIOD;
        #(limit_ns);
        $display("Watchdog timeout after %0d ns, vector %0d never got its event",
                 limit_ns, waiting_vec);
        $display("Errors: %0d, events seen: %0d, events expected: %0d",
                 errors, events_seen, events_expected);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* dv/vdp_vectors.txt */
// Columns, all hex: mode data kind idx value
// kind 0 none, 1 VRAM write with idx as address, 2 register write with idx as number
// Data writes from the reset address
0 A5 1 0000 A5
0 5A 1 0001 5A
// Address load 1234 then data writes
1 34 0 0000 00
1 52 0 0000 00
0 11 1 1234 11
0 22 1 1235 22
0 33 1 1236 33
// Register writes leave the address alone
1 E0 0 0000 00
1 81 2 0001 E0
0 44 1 1237 44
1 F4 0 0000 00
1 87 2 0007 F4
1 0E 0 0000 00
1 FA 2 0002 0E
0 55 1 1238 55
// Address wrap from 3FFE
1 FE 0 0000 00
1 7F 0 0000 00
0 66 1 3FFE 66
0 77 1 3FFF 77
0 88 1 0000 88
0 99 1 0001 99
// Half pair broken by a data write
1 C3 0 0000 00
0 AA 1 0002 AA
1 3C 0 0000 00
1 85 2 0005 3C
0 BB 1 0003 BB
1 83 0 0000 00
0 CC 1 0004 CC
1 00 0 0000 00
1 40 0 0000 00
0 DD 1 0000 DD
// Load 3FFF, wrap again, register 0
1 FF 0 0000 00
1 3F 0 0000 00
0 EE 1 3FFF EE
0 01 1 0000 01
1 02 0 0000 00
1 80 2 0000 02
0 F0 1 0001 F0

/* project.f */
+incdir+src
src/vdp_pkg.sv
src/cpu_wr_port.sv
src/wr_cdc.sv
src/vdp_port_decode.sv
src/z80_vdp_bus.sv
dv/tb_z80_vdp_bus.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the Z80 VDP write path testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
    -f project.f --top-module tb_z80_vdp_bus -o tb_sim \
    && ./obj_dir/tb_sim > "$LOG" 2>&1 \
    || { echo "Build or simulation run failed"; exit 1; }

cat "$LOG"
grep -qx "Simulation passed" "$LOG" \
    && { echo "RESULT: PASS"; exit 0; } \
    || { echo "RESULT: FAIL"; exit 1; }

/* src/cpu_wr_port.sv */
//******************************
// CPU write capture, phi domain
// Holds each port write and flips a request toggle
//******************************

`timescale 1ns/10ps

`include "vdp_params.svh"

module cpu_wr_port (
    input  logic                    phi,            // Z80 PHI clock
    input  logic                    rst_n,
    input  logic                    cpu_wr_tick,    // One phi cycle per write
    input  logic                    cpu_mode,       // Port select, valid with tick
    input  logic [`VDP_DATA_W-1:0]  cpu_din,        // Data, valid with tick
    output vdp_pkg::cpu_wr_t        cap_wr,         // Held until the next write
    output logic                    req_toggle      // Flips once per write
);

    //******************************
    // Request toggle
    //******************************

    // A level change instead of a pulse, so the slow pxclk side cannot miss it
    always_ff @(posedge phi or negedge rst_n) begin
        if (!rst_n) begin
            req_toggle <= 1'b0;
        end else if (cpu_wr_tick) begin
            req_toggle <= ~req_toggle;
        end
    end

    //******************************
    // Write payload
    //******************************

    // Loaded on the same edge as the toggle flip
    always_ff @(posedge phi) begin
        if (cpu_wr_tick) begin
            cap_wr.mode <= cpu_mode;
            cap_wr.data <= cpu_din;     // Stable long after the crossing samples it
        end
    end

endmodule

/* src/vdp_params.svh */
//******************************
// VDP write path parameters
// Bus widths, register count and CPU write spacing
//******************************

`ifndef VDP_PARAMS_SVH
`define VDP_PARAMS_SVH

// Bus widths
`define VDP_DATA_W      8       // CPU data byte
`define VDP_ADDR_W      14      // VRAM address, wraps at 16K
`define VDP_REG_NUM_W   3       // Eight control registers

// Clock crossing
`define VDP_SYNC_STAGES 2       // Synchronizer flops, 2 or more

// Minimum phi cycles between two CPU write ticks
`define VDP_MIN_WR_GAP  6

`endif

/* src/vdp_pkg.sv */
//******************************
// VDP write path types
// Port write, VRAM write and register write buses
//******************************

`include "vdp_params.svh"

package vdp_pkg;

    // One CPU port write as captured on phi
    typedef struct packed {
        logic                       mode;   // 0 data port, 1 control port
        logic [`VDP_DATA_W-1:0]     data;   // Byte from the Z80
    } cpu_wr_t;

    // VRAM write toward the memory side
    typedef struct packed {
        logic                       we;     // One pxclk cycle strobe
        logic [`VDP_ADDR_W-1:0]     addr;
        logic [`VDP_DATA_W-1:0]     data;
    } vram_wr_t;

    // Control register write
    typedef struct packed {
        logic                       we;     // One pxclk cycle strobe
        logic [`VDP_REG_NUM_W-1:0]  num;    // Register number
        logic [`VDP_DATA_W-1:0]     val;    // New register value
    } reg_wr_t;

    // Control port pair tracking
    typedef enum logic [1:0] {
        CTL_IDLE   = 2'd0,  // Waiting for first byte of a pair
        CTL_SECOND = 2'd1   // First byte held, second byte decides
    } ctl_state_t;

endpackage

/* src/vdp_port_decode.sv */
//******************************
// VDP port decoder, pxclk domain
// Data port VRAM writes with address auto increment,
// control port pairs for address load and register writes
//******************************

`timescale 1ns/10ps

`include "vdp_params.svh"

module vdp_port_decode (
    input  logic                pxclk,          // Pixel clock
    input  logic                rst_n,
    input  logic                px_wr_tick,     // One cycle per CPU write
    input  vdp_pkg::cpu_wr_t    px_wr,          // Mode and byte, valid with tick
    output vdp_pkg::vram_wr_t   vram_wr,        // VRAM write event
    output vdp_pkg::reg_wr_t    reg_wr          // Register write event
);

    import vdp_pkg::*;

    ctl_state_t                     state_q;        // Control pair position
    logic [`VDP_DATA_W-1:0]         first_q;        // First byte of a control pair
    logic [`VDP_ADDR_W-1:0]         addr_q;         // Current VRAM address
    logic                           vram_we_q;
    logic [`VDP_ADDR_W-1:0]         vram_addr_q;
    logic [`VDP_DATA_W-1:0]         vram_data_q;
    logic                           reg_we_q;
    logic [`VDP_REG_NUM_W-1:0]      reg_num_q;
    logic [`VDP_DATA_W-1:0]         reg_val_q;

    logic                           data_wr;        // Data port write this cycle
    logic                           ctl_wr;         // Control port write this cycle
    logic                           ctl_second;     // Second byte of a pair arrives

    assign data_wr    = px_wr_tick && !px_wr.mode;
    assign ctl_wr     = px_wr_tick && px_wr.mode;
    assign ctl_second = ctl_wr && (state_q == CTL_SECOND);

    //******************************
    // Control state and address
    //******************************

    always_ff @(posedge pxclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= CTL_IDLE;
            addr_q  <= '0;
        end else if (data_wr) begin
            state_q <= CTL_IDLE;                // Data access breaks a half pair
            addr_q  <= addr_q + 1'b1;           // Wraps at 3FFF
        end else if (ctl_wr) begin
            if (state_q == CTL_IDLE) begin
                state_q <= CTL_SECOND;
            end else begin
                state_q <= CTL_IDLE;
                if (!px_wr.data[7]) begin
                    // High six bits from the second byte, low byte from the first
                    addr_q <= {px_wr.data[`VDP_ADDR_W-`VDP_DATA_W-1:0], first_q};
                end
            end
        end
    end

    // First byte latch, only meaningful in CTL_SECOND
    always_ff @(posedge pxclk) begin
        if (ctl_wr && state_q == CTL_IDLE) begin
            first_q <= px_wr.data;
        end
    end

    //******************************
    // Output strobes
    //******************************

    always_ff @(posedge pxclk or negedge rst_n) begin
        if (!rst_n) begin
            vram_we_q <= 1'b0;
            reg_we_q  <= 1'b0;
        end else begin
            vram_we_q <= data_wr;
            reg_we_q  <= ctl_second && px_wr.data[7];   // Bit 7 set selects a register
        end
    end

    always_ff @(posedge pxclk) begin
        if (data_wr) begin
            vram_addr_q <= addr_q;              // Address before the increment
            vram_data_q <= px_wr.data;
        end
        if (ctl_second) begin
            reg_num_q <= px_wr.data[`VDP_REG_NUM_W-1:0];
            reg_val_q <= first_q;
        end
    end

    assign vram_wr = '{we: vram_we_q, addr: vram_addr_q, data: vram_data_q};
    assign reg_wr  = '{we: reg_we_q, num: reg_num_q, val: reg_val_q};

endmodule

/* src/wr_cdc.sv */
//******************************
// CPU write clock crossing
// Synchronizes the request toggle into pxclk and
// presents the held write with a one cycle strobe
//******************************

`timescale 1ns/10ps

`include "vdp_params.svh"

module wr_cdc (
    input  logic                pxclk,          // Pixel clock
    input  logic                rst_n,
    input  logic                req_toggle,     // phi domain level
    input  vdp_pkg::cpu_wr_t    cap_wr,         // phi domain, quasi static
    output vdp_pkg::cpu_wr_t    px_wr,          // pxclk domain copy
    output logic                px_wr_tick      // One pxclk cycle per write
);

    localparam int SYNC_MSB = `VDP_SYNC_STAGES - 1;

    logic [SYNC_MSB:0]  sync_q;     // Synchronizer chain, bit 0 sees req_toggle first
    logic               tog_seen_q; // Last toggle level already turned into a strobe
    logic               tog_edge;   // Synchronized toggle differs from last seen

    //******************************
    // Toggle synchronizer
    //******************************

    always_ff @(posedge pxclk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q     <= '0;
            tog_seen_q <= 1'b0;
        end else begin
            sync_q     <= {sync_q[SYNC_MSB-1:0], req_toggle};   // Shift in toward MSB
            tog_seen_q <= sync_q[SYNC_MSB];
        end
    end

    // Either direction of the toggle is one new write
    assign tog_edge = sync_q[SYNC_MSB] ^ tog_seen_q;

    //******************************
    // Strobe and payload
    //******************************

    always_ff @(posedge pxclk or negedge rst_n) begin
        if (!rst_n) begin
            px_wr_tick <= 1'b0;
        end else begin
            px_wr_tick <= tog_edge;     // Exactly one cycle, tog_seen_q catches up
        end
    end

    // cap_wr settled at least SYNC_STAGES pxclk edges before this point
    always_ff @(posedge pxclk) begin
        if (tog_edge) begin
            px_wr <= cap_wr;
        end
    end

endmodule

/* src/z80_vdp_bus.sv */
//******************************
// Z80 to VDP write path top
// phi side capture, clock crossing, port decoding
//******************************

`timescale 1ns/10ps

`include "vdp_params.svh"

module z80_vdp_bus (
    input  logic                    phi,            // Z80 PHI clock
    input  logic                    pxclk,          // Pixel clock
    input  logic                    rst_n,
    input  logic                    cpu_wr_tick,    // phi domain strobe
    input  logic                    cpu_mode,       // Port select
    input  logic [`VDP_DATA_W-1:0]  cpu_din,        // Write data
    output vdp_pkg::vram_wr_t       vram_wr,        // pxclk domain
    output vdp_pkg::reg_wr_t        reg_wr          // pxclk domain
);

    import vdp_pkg::*;

    cpu_wr_t    cap_wr;         // phi domain, held between writes
    logic       req_toggle;     // phi domain, one flip per write
    cpu_wr_t    px_wr;          // pxclk domain copy of the write
    logic       px_wr_tick;     // pxclk domain strobe

    // Producer on phi
    cpu_wr_port u_wr_port (
        .phi         (phi),
        .rst_n       (rst_n),
        .cpu_wr_tick (cpu_wr_tick),
        .cpu_mode    (cpu_mode),
        .cpu_din     (cpu_din),
        .cap_wr      (cap_wr),
        .req_toggle  (req_toggle)
    );

    // phi to pxclk
    wr_cdc u_wr_cdc (
        .pxclk       (pxclk),
        .rst_n       (rst_n),
        .req_toggle  (req_toggle),
        .cap_wr      (cap_wr),
        .px_wr       (px_wr),
        .px_wr_tick  (px_wr_tick)
    );

    // Consumer on pxclk
    vdp_port_decode u_decode (
        .pxclk       (pxclk),
        .rst_n       (rst_n),
        .px_wr_tick  (px_wr_tick),
        .px_wr       (px_wr),
        .vram_wr     (vram_wr),
        .reg_wr      (reg_wr)
    );

endmodule
